//--- arcade_cfg_pkg.sv
package arcade_cfg_pkg;

	typedef logic [3:0]  apb_addr_t;
	typedef logic [15:0] coin_count_t;

	// register map, byte addresses
	localparam apb_addr_t ADDR_CFG   = 4'h0;
	localparam apb_addr_t ADDR_CTRL  = 4'h4;
	localparam apb_addr_t ADDR_COINS = 4'h8;
	localparam apb_addr_t ADDR_RESET = 4'hC;

	localparam int RESET_CYCLES = 16; // core reset pulse length

	typedef enum logic [1:0] {
		SL_OFF,
		SL_25,
		SL_50,
		SL_75
	} scanline_e;

	// laid out as the CFG register: scanlines in 2:1, rotate in 0
	typedef struct packed {
		scanline_e scanlines;
		logic      rotate;
	} cfg_t;

	typedef enum logic [1:0] {
		APB_IDLE,
		APB_SETUP,
		APB_ACCESS
	} apb_state_e;

endpackage

//--- arcade_io_pkg.sv
package arcade_io_pkg;

	typedef logic [7:0] key_code_t;  // ps/2 set 2
	typedef logic [7:0] joystick_t;
	typedef logic [5:0] color_t;
	typedef logic [7:0] sample_t;    // unsigned

	localparam key_code_t KEY_UP     = 8'h75;
	localparam key_code_t KEY_DOWN   = 8'h72;
	localparam key_code_t KEY_LEFT   = 8'h6B;
	localparam key_code_t KEY_RIGHT  = 8'h74;
	localparam key_code_t KEY_COIN   = 8'h76; // esc
	localparam key_code_t KEY_START1 = 8'h05; // f1
	localparam key_code_t KEY_START2 = 8'h06; // f2
	localparam key_code_t KEY_FIRE1  = 8'h29; // space
	localparam key_code_t KEY_FIRE2  = 8'h11; // alt

	// joystick word bit positions
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE1 = 4;
	localparam int JOY_FIRE2 = 5;

	typedef struct packed {
		logic      strobe;
		logic      pressed;
		key_code_t code;
	} key_event_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
		logic start1;
		logic start2;
		logic coin;
		logic spare;
	} buttons_t;

	typedef buttons_t player_ctrl_t;

	typedef struct packed {
		color_t r;
		color_t g;
		color_t b;
		logic   hs; // active high
		logic   vs;
	} video_t;

endpackage

//--- key_decoder.sv
`timescale 1ns/1ns

module key_decoder (
	input  logic                     clk_mist,
	input  logic                     rst,
	input  arcade_io_pkg::key_event_t key_ev,
	output arcade_io_pkg::buttons_t   kb_buttons
);

	always_ff @(posedge clk_mist) begin
		if (rst) begin
			kb_buttons <= '0;
		end else if (key_ev.strobe) begin
			case (key_ev.code)
				arcade_io_pkg::KEY_UP: begin
					kb_buttons.up <= key_ev.pressed;
				end
				arcade_io_pkg::KEY_DOWN: begin
					kb_buttons.down <= key_ev.pressed;
				end
				arcade_io_pkg::KEY_LEFT: begin
					kb_buttons.left <= key_ev.pressed;
				end
				arcade_io_pkg::KEY_RIGHT: begin
					kb_buttons.right <= key_ev.pressed;
				end
				arcade_io_pkg::KEY_FIRE1: begin
					kb_buttons.fire1 <= key_ev.pressed;
				end
				arcade_io_pkg::KEY_FIRE2: begin
					kb_buttons.fire2 <= key_ev.pressed;
				end
				arcade_io_pkg::KEY_START1: begin
					kb_buttons.start1 <= key_ev.pressed;
				end
				arcade_io_pkg::KEY_START2: begin
					kb_buttons.start2 <= key_ev.pressed;
				end
				arcade_io_pkg::KEY_COIN: begin
					kb_buttons.coin <= key_ev.pressed;
				end
				default: begin
					kb_buttons <= kb_buttons; // other keys ignored
				end
			endcase
		end
	end

endmodule

//--- control_mapper.sv
`timescale 1ns/1ns

module control_mapper (
	input  logic                       clk_mist,
	input  logic                       rst,
	input  arcade_io_pkg::buttons_t     kb_buttons,
	input  arcade_io_pkg::joystick_t    joy_0,
	input  arcade_io_pkg::joystick_t    joy_1,
	input  logic                       rotate,
	output arcade_io_pkg::player_ctrl_t player
);

	logic raw_up;
	logic raw_down;
	logic raw_left;
	logic raw_right;
	logic raw_fire1;
	logic raw_fire2;

	// keyboard or either stick
	assign raw_up    = kb_buttons.up | joy_0[arcade_io_pkg::JOY_UP] | joy_1[arcade_io_pkg::JOY_UP];
	assign raw_down  = kb_buttons.down | joy_0[arcade_io_pkg::JOY_DOWN] |
		joy_1[arcade_io_pkg::JOY_DOWN];
	assign raw_left  = kb_buttons.left | joy_0[arcade_io_pkg::JOY_LEFT] |
		joy_1[arcade_io_pkg::JOY_LEFT];
	assign raw_right = kb_buttons.right | joy_0[arcade_io_pkg::JOY_RIGHT] |
		joy_1[arcade_io_pkg::JOY_RIGHT];
	assign raw_fire1 = kb_buttons.fire1 | joy_0[arcade_io_pkg::JOY_FIRE1] |
		joy_1[arcade_io_pkg::JOY_FIRE1];
	assign raw_fire2 = kb_buttons.fire2 | joy_0[arcade_io_pkg::JOY_FIRE2] |
		joy_1[arcade_io_pkg::JOY_FIRE2];

	always_ff @(posedge clk_mist) begin
		if (rst) begin
			player <= '0;
		end else begin
			player.up     <= rotate ? raw_right : raw_up; // quarter turn for vertical cabs
			player.down   <= rotate ? raw_left  : raw_down;
			player.left   <= rotate ? raw_up    : raw_left;
			player.right  <= rotate ? raw_down  : raw_right;
			player.fire1  <= raw_fire1;
			player.fire2  <= raw_fire2;
			player.start1 <= kb_buttons.start1;
			player.start2 <= kb_buttons.start2;
			player.coin   <= kb_buttons.coin;
			player.spare  <= 1'b0;
		end
	end

endmodule

//--- io_ctrl.sv
`timescale 1ns/1ns

module io_ctrl (
	input  logic                       clk_mist,
	input  logic                       rst,
	input  arcade_cfg_pkg::apb_addr_t   paddr,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [31:0]                pwdata,
	output logic [31:0]                prdata,
	output logic                       pready,
	output logic                       pslverr,
	input  arcade_io_pkg::player_ctrl_t player,
	output arcade_cfg_pkg::cfg_t        cfg,
	output logic                       core_rst
);

	typedef logic [$clog2(arcade_cfg_pkg::RESET_CYCLES + 1)-1:0] rst_cnt_t;

	arcade_cfg_pkg::apb_state_e  state;
	arcade_cfg_pkg::apb_state_e  state_next;
	arcade_cfg_pkg::coin_count_t coins;
	rst_cnt_t                    rst_cnt;
	logic                        coin_q;
	logic                        addr_ok;
	logic                        wr_en;

	always_comb begin
		state_next = state;
		case (state)
			arcade_cfg_pkg::APB_IDLE: begin
				if (psel && !penable)
					state_next = arcade_cfg_pkg::APB_ACCESS; // setup phase seen
			end
			default: begin
				state_next = arcade_cfg_pkg::APB_IDLE; // one access cycle only
			end
		endcase
	end

	always_ff @(posedge clk_mist) begin
		if (rst)
			state <= arcade_cfg_pkg::APB_IDLE;
		else
			state <= state_next;
	end

	// register decode
	always_comb begin
		addr_ok = 1'b1;
		prdata  = '0;
		case (paddr)
			arcade_cfg_pkg::ADDR_CFG:   prdata = {29'd0, cfg};
			arcade_cfg_pkg::ADDR_CTRL:  prdata = {22'd0, player};
			arcade_cfg_pkg::ADDR_COINS: prdata = {16'd0, coins};
			arcade_cfg_pkg::ADDR_RESET: prdata = '0; // write only
			default:                    addr_ok = 1'b0;
		endcase
	end

	assign pready  = (state == arcade_cfg_pkg::APB_ACCESS);
	assign pslverr = pready && !addr_ok;
	assign wr_en   = pready && psel && pwrite;

	always_ff @(posedge clk_mist) begin
		if (rst) begin
			cfg <= '0;
		end else if (wr_en && paddr == arcade_cfg_pkg::ADDR_CFG) begin
			cfg.rotate    <= pwdata[0];
			cfg.scanlines <= arcade_cfg_pkg::scanline_e'(pwdata[2:1]);
		end
	end

	always_ff @(posedge clk_mist) begin
		if (rst) begin
			coin_q <= 1'b0;
			coins  <= '0;
		end else begin
			coin_q <= player.coin;
			if (wr_en && paddr == arcade_cfg_pkg::ADDR_COINS)
				coins <= '0; // clear beats a coin edge
			else if (player.coin && !coin_q)
				coins <= coins + 1'b1;
		end
	end

	always_ff @(posedge clk_mist) begin
		if (rst)
			rst_cnt <= '0;
		else if (wr_en && paddr == arcade_cfg_pkg::ADDR_RESET)
			rst_cnt <= rst_cnt_t'(arcade_cfg_pkg::RESET_CYCLES); // restarts if busy
		else if (rst_cnt != '0)
			rst_cnt <= rst_cnt - 1'b1;
	end

	assign core_rst = (rst_cnt != '0);

endmodule

//--- audio_dac.sv
`timescale 1ns/1ns

module audio_dac (
	input  logic                   clk_mist,
	input  logic                   rst,
	input  arcade_io_pkg::sample_t sample,
	output logic                   audio_out
);

	logic [8:0] acc; // bit 8 holds last carry

	always_ff @(posedge clk_mist) begin
		if (rst)
			acc <= '0;
		else
			acc <= {1'b0, acc[7:0]} + {1'b0, sample};
	end

	assign audio_out = acc[8];

endmodule

//--- scanline_dimmer.sv
`timescale 1ns/1ns

module scanline_dimmer (
	input  logic                      clk_mist,
	input  logic                      rst,
	input  arcade_io_pkg::video_t     video_in,
	input  arcade_cfg_pkg::scanline_e scanlines,
	output arcade_io_pkg::video_t     video_out
);

	logic hs_q;
	logic odd_line;

	function automatic arcade_io_pkg::color_t dim(
		input arcade_io_pkg::color_t     c,
		input arcade_cfg_pkg::scanline_e lvl
	);
		arcade_io_pkg::color_t res;
		case (lvl)
			arcade_cfg_pkg::SL_25: res = c - (c >> 2);
			arcade_cfg_pkg::SL_50: res = c >> 1;
			arcade_cfg_pkg::SL_75: res = c >> 2;
			default:               res = c;
		endcase
		return res;
	endfunction

	always_ff @(posedge clk_mist) begin
		if (rst) begin
			hs_q     <= 1'b0;
			odd_line <= 1'b0;
		end else begin
			hs_q <= video_in.hs;
			if (hs_q && !video_in.hs)
				odd_line <= ~odd_line; // new line starts at hs fall
		end
	end

	always_ff @(posedge clk_mist) begin
		if (rst) begin
			video_out <= '0;
		end else begin
			video_out.r  <= odd_line ? dim(video_in.r, scanlines) : video_in.r;
			video_out.g  <= odd_line ? dim(video_in.g, scanlines) : video_in.g;
			video_out.b  <= odd_line ? dim(video_in.b, scanlines) : video_in.b;
			video_out.hs <= video_in.hs;
			video_out.vs <= video_in.vs;
		end
	end

endmodule

//--- arcade_io_top.sv
`timescale 1ns/1ns

module arcade_io_top (
	input  logic                       clk_mist,
	input  logic                       rst,
	input  arcade_cfg_pkg::apb_addr_t   paddr,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [31:0]                pwdata,
	output logic [31:0]                prdata,
	output logic                       pready,
	output logic                       pslverr,
	input  arcade_io_pkg::key_event_t   key_ev,
	input  arcade_io_pkg::joystick_t    joy_0,
	input  arcade_io_pkg::joystick_t    joy_1,
	input  arcade_io_pkg::video_t       video_in,
	input  arcade_io_pkg::sample_t      sample,
	output arcade_io_pkg::video_t       video_out,
	output logic                       audio_l,
	output logic                       audio_r,
	output arcade_io_pkg::player_ctrl_t player,
	output logic                       core_rst
);

	arcade_io_pkg::buttons_t kb_buttons;
	arcade_cfg_pkg::cfg_t    cfg;
	logic                    audio_bit;

	key_decoder u_key_decoder (
		.clk_mist   (clk_mist),
		.rst        (rst),
		.key_ev     (key_ev),
		.kb_buttons (kb_buttons)
	);

	control_mapper u_control_mapper (
		.clk_mist   (clk_mist),
		.rst        (rst),
		.kb_buttons (kb_buttons),
		.joy_0      (joy_0),
		.joy_1      (joy_1),
		.rotate     (cfg.rotate),
		.player     (player)
	);

	io_ctrl u_io_ctrl (
		.clk_mist (clk_mist),
		.rst      (rst),
		.paddr    (paddr),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.player   (player),
		.cfg      (cfg),
		.core_rst (core_rst)
	);

	audio_dac u_audio_dac (
		.clk_mist  (clk_mist),
		.rst       (rst),
		.sample    (sample),
		.audio_out (audio_bit)
	);

	scanline_dimmer u_scanline_dimmer (
		.clk_mist  (clk_mist),
		.rst       (rst),
		.video_in  (video_in),
		.scanlines (cfg.scanlines),
		.video_out (video_out)
	);

	assign audio_l = audio_bit; // mono to both channels
	assign audio_r = audio_bit;

endmodule

//--- arcade_io_checker.sv
`timescale 1ns/1ns

module arcade_io_checker (
	input logic                        clk_mist,
	input logic                        rst,
	input arcade_cfg_pkg::apb_addr_t   paddr,
	input logic                        psel,
	input logic                        penable,
	input logic                        pwrite,
	input logic [31:0]                 pwdata,
	input logic [31:0]                 prdata,
	input logic                        pready,
	input logic                        pslverr,
	input arcade_io_pkg::key_event_t   key_ev,
	input arcade_io_pkg::joystick_t    joy_0,
	input arcade_io_pkg::joystick_t    joy_1,
	input arcade_io_pkg::video_t       video_in,
	input arcade_io_pkg::sample_t      sample,
	input arcade_io_pkg::video_t       video_out,
	input logic                        audio_l,
	input logic                        audio_r,
	input arcade_io_pkg::player_ctrl_t player,
	input logic                        core_rst
);

	arcade_io_pkg::buttons_t     m_kb;
	arcade_io_pkg::player_ctrl_t m_player;
	arcade_io_pkg::player_ctrl_t m_player_n;
	arcade_cfg_pkg::cfg_t        m_cfg;
	arcade_cfg_pkg::coin_count_t m_coins;
	arcade_io_pkg::video_t       m_video;
	arcade_io_pkg::video_t       m_video_n;
	arcade_io_pkg::sample_t      dac_sample;
	arcade_io_pkg::sample_t      win_sample;
	logic m_coin_q;
	logic m_hs_q;
	logic m_odd;
	logic mapped;
	logic access;
	logic wr;
	logic primed = 1'b0;
	logic dac_valid = 1'b0;
	int   m_rst_left;
	int   win_len = 0;
	int   win_ones = 0;
	int   test_errs = 0;
	int   tests_ok = 0;
	int   tests_bad = 0;

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			$display("Fail %s exp %h got %h", name, exp, got);
			test_errs++;
		end
	endtask

	task automatic end_test(input string name);
		if (test_errs == 0) begin
			$display("test %s: ok", name);
			tests_ok++;
		end else begin
			$display("test %s: %0d mismatches", name, test_errs);
			tests_bad++;
		end
		test_errs = 0;
	endtask

	task automatic print_counts();
		$display("tests passed %0d, tests failed %0d", tests_ok, tests_bad);
	endtask

	function automatic arcade_io_pkg::player_ctrl_t map_controls(
		input arcade_io_pkg::buttons_t kb,
		input arcade_io_pkg::joystick_t j0,
		input arcade_io_pkg::joystick_t j1,
		input logic rot
	);
		arcade_io_pkg::player_ctrl_t p;
		logic [3:0] dir; // up, down, left, right
		dir = {kb.up | j0[3] | j1[3], kb.down | j0[2] | j1[2],
			kb.left | j0[1] | j1[1], kb.right | j0[0] | j1[0]};
		p = kb; // start and coin from keys only
		p.spare = 1'b0;
		p.fire1 = kb.fire1 | j0[4] | j1[4];
		p.fire2 = kb.fire2 | j0[5] | j1[5];
		{p.up, p.down, p.left, p.right} = rot ? {dir[0], dir[1], dir[3], dir[2]} : dir;
		return p;
	endfunction

	function automatic arcade_io_pkg::buttons_t apply_key(
		input arcade_io_pkg::buttons_t b,
		input arcade_io_pkg::key_event_t ev
	);
		case (ev.code)
			arcade_io_pkg::KEY_UP:     b.up = ev.pressed;
			arcade_io_pkg::KEY_DOWN:   b.down = ev.pressed;
			arcade_io_pkg::KEY_LEFT:   b.left = ev.pressed;
			arcade_io_pkg::KEY_RIGHT:  b.right = ev.pressed;
			arcade_io_pkg::KEY_FIRE1:  b.fire1 = ev.pressed;
			arcade_io_pkg::KEY_FIRE2:  b.fire2 = ev.pressed;
			arcade_io_pkg::KEY_START1: b.start1 = ev.pressed;
			arcade_io_pkg::KEY_START2: b.start2 = ev.pressed;
			arcade_io_pkg::KEY_COIN:   b.coin = ev.pressed;
			default: ;
		endcase
		return b;
	endfunction

	function automatic arcade_io_pkg::color_t dim(
		input arcade_io_pkg::color_t c,
		input arcade_cfg_pkg::scanline_e lvl
	);
		case (lvl)
			arcade_cfg_pkg::SL_25: return c - c / 4;
			arcade_cfg_pkg::SL_50: return c / 2;
			arcade_cfg_pkg::SL_75: return c / 4;
			default:               return c;
		endcase
	endfunction

	function automatic logic [31:0] read_value(input arcade_cfg_pkg::apb_addr_t a);
		case (a)
			arcade_cfg_pkg::ADDR_CFG:   return {29'd0, m_cfg.scanlines, m_cfg.rotate};
			arcade_cfg_pkg::ADDR_CTRL:  return {22'd0, m_player};
			arcade_cfg_pkg::ADDR_COINS: return {16'd0, m_coins};
			default:                    return '0;
		endcase
	endfunction

	// compare the settled outputs, then step the model over the coming edge
	always @(negedge clk_mist) begin
		mapped = (paddr == arcade_cfg_pkg::ADDR_CFG) || (paddr == arcade_cfg_pkg::ADDR_CTRL) ||
			(paddr == arcade_cfg_pkg::ADDR_COINS) || (paddr == arcade_cfg_pkg::ADDR_RESET);
		access = psel && penable; // zero wait, one cycle per access
		wr = access && pwrite; // transfer ends on this edge
		if (primed) begin
			check("player", 32'(m_player), 32'(player));
			check("core_rst", 32'(m_rst_left != 0), 32'(core_rst));
			check("video_out", 32'(m_video), 32'(video_out));
			check("audio_r", 32'(audio_l), 32'(audio_r));
			check("pready", 32'(access), 32'(pready));
			check("pslverr", 32'(access && !mapped), 32'(pslverr));
			if (access && !pwrite && mapped)
				check("prdata", read_value(paddr), prdata);
			if (dac_valid) begin
				if (win_len == 0 || dac_sample != win_sample) begin
					win_sample = dac_sample;
					win_len = 0;
					win_ones = 0;
				end
				win_ones += int'(audio_l);
				win_len++;
				if (win_len == 256) begin
					check("audio_l ones", 32'(win_sample), win_ones);
					win_len = 0;
				end
			end
		end
		if (rst) begin
			m_kb = '0;
			m_player = '0;
			m_cfg = '0;
			m_coins = '0;
			m_coin_q = 1'b0;
			m_rst_left = 0;
			m_hs_q = 1'b0;
			m_odd = 1'b0;
			m_video = '0;
			primed = 1'b1;
		end else begin
			m_player_n = map_controls(m_kb, joy_0, joy_1, m_cfg.rotate);
			m_video_n = video_in;
			if (m_odd) begin
				m_video_n.r = dim(video_in.r, m_cfg.scanlines);
				m_video_n.g = dim(video_in.g, m_cfg.scanlines);
				m_video_n.b = dim(video_in.b, m_cfg.scanlines);
			end
			if (key_ev.strobe)
				m_kb = apply_key(m_kb, key_ev);
			if (m_hs_q && !video_in.hs)
				m_odd = !m_odd; // next line
			m_hs_q = video_in.hs;
			if (wr && paddr == arcade_cfg_pkg::ADDR_COINS)
				m_coins = '0;
			else if (m_player.coin && !m_coin_q)
				m_coins = m_coins + 1'b1;
			m_coin_q = m_player.coin;
			if (wr && paddr == arcade_cfg_pkg::ADDR_RESET)
				m_rst_left = arcade_cfg_pkg::RESET_CYCLES;
			else if (m_rst_left > 0)
				m_rst_left--;
			if (wr && paddr == arcade_cfg_pkg::ADDR_CFG) begin
				m_cfg.rotate = pwdata[0];
				m_cfg.scanlines = arcade_cfg_pkg::scanline_e'(pwdata[2:1]);
			end
			m_player = m_player_n;
			m_video = m_video_n;
		end
		dac_sample = sample; // added on the coming edge
		dac_valid = !rst;
	end

endmodule

//--- tb_arcade_io.sv
`timescale 1ns/1ns

module tb_arcade_io;

	localparam int APB_TIMEOUT = 8;
	localparam int PULSE_TIMEOUT = 40;

	logic                        clk_mist;
	logic                        rst;
	arcade_cfg_pkg::apb_addr_t   paddr;
	logic                        psel;
	logic                        penable;
	logic                        pwrite;
	logic [31:0]                 pwdata;
	logic [31:0]                 prdata;
	logic                        pready;
	logic                        pslverr;
	arcade_io_pkg::key_event_t   key_ev;
	arcade_io_pkg::joystick_t    joy_0;
	arcade_io_pkg::joystick_t    joy_1;
	arcade_io_pkg::video_t       video_in;
	arcade_io_pkg::sample_t      sample;
	arcade_io_pkg::video_t       video_out;
	logic                        audio_l;
	logic                        audio_r;
	arcade_io_pkg::player_ctrl_t player;
	logic                        core_rst;
	logic                        timed_out;

	arcade_io_top u_dut (.*);

	arcade_io_checker u_chk (.*);

	initial begin
		clk_mist = 1'b0;
		forever #20 clk_mist = ~clk_mist;
	end

	task automatic next_cycle();
		@(posedge clk_mist);
		#2;
	endtask

	task automatic send_key(input arcade_io_pkg::key_code_t code, input logic pressed);
		next_cycle();
		key_ev = '{strobe: 1'b1, pressed: pressed, code: code};
		next_cycle();
		key_ev.strobe = 1'b0;
	endtask

	function automatic arcade_io_pkg::key_code_t random_code();
		case ($urandom_range(11))
			0: return arcade_io_pkg::KEY_UP;
			1: return arcade_io_pkg::KEY_DOWN;
			2: return arcade_io_pkg::KEY_LEFT;
			3: return arcade_io_pkg::KEY_RIGHT;
			4: return arcade_io_pkg::KEY_FIRE1;
			5: return arcade_io_pkg::KEY_FIRE2;
			6: return arcade_io_pkg::KEY_START1;
			7: return arcade_io_pkg::KEY_START2;
			8: return arcade_io_pkg::KEY_COIN;
			default: return 8'($urandom); // mostly unmapped codes
		endcase
	endfunction

	task automatic apb_access(input arcade_cfg_pkg::apb_addr_t addr, input logic wr,
		input logic [31:0] data);
		int waited;
		next_cycle();
		paddr = addr;
		pwrite = wr;
		pwdata = data;
		psel = 1'b1;
		penable = 1'b0;
		next_cycle();
		penable = 1'b1;
		waited = 0;
		@(negedge clk_mist);
		while (!pready && waited < APB_TIMEOUT) begin
			@(negedge clk_mist);
			waited++;
		end
		if (!pready) begin
			$display("timeout: no pready from the DUT for address %h", addr);
			timed_out = 1'b1;
		end
		next_cycle();
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic wait_reset_done();
		int n;
		n = 0;
		while (core_rst && n < PULSE_TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (core_rst) begin
			$display("timeout: core_rst stayed high for %0d cycles", n);
			timed_out = 1'b1;
		end
	endtask

	initial begin
		void'($urandom(32'h6fcd));
		rst = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		key_ev = '0;
		joy_0 = '0;
		joy_1 = '0;
		video_in = '0;
		sample = '0;
		timed_out = 1'b0;
		repeat (3) @(posedge clk_mist);
		#2;
		rst = 1'b0;

		repeat (150) send_key(random_code(), 1'($urandom));
		u_chk.end_test("key events");

		for (int rot = 0; rot < 2; rot++) begin
			apb_access(arcade_cfg_pkg::ADDR_CFG, 1'b1, 32'(rot));
			repeat (120) begin
				next_cycle();
				joy_0 = 8'($urandom);
				joy_1 = 8'($urandom);
				if ($urandom_range(3) == 0)
					send_key(random_code(), 1'($urandom));
			end
		end
		joy_0 = '0;
		joy_1 = '0;
		u_chk.end_test("joystick merge and rotation");

		apb_access(arcade_cfg_pkg::ADDR_CFG, 1'b1, 32'h5);
		apb_access(arcade_cfg_pkg::ADDR_CFG, 1'b0, '0);
		joy_0 = 8'($urandom);
		apb_access(arcade_cfg_pkg::ADDR_CTRL, 1'b0, '0);
		for (int a = 0; a < 16; a++)
			apb_access(4'(a), 1'b0, '0); // sweep whole map for pslverr
		apb_access(4'h2, 1'b1, $urandom);
		apb_access(4'hF, 1'b1, $urandom);
		repeat (5) begin
			send_key(arcade_io_pkg::KEY_COIN, 1'b1);
			send_key(arcade_io_pkg::KEY_COIN, 1'b0);
		end
		apb_access(arcade_cfg_pkg::ADDR_COINS, 1'b0, '0);
		apb_access(arcade_cfg_pkg::ADDR_COINS, 1'b1, '0);
		apb_access(arcade_cfg_pkg::ADDR_COINS, 1'b0, '0);
		joy_0 = '0;
		u_chk.end_test("apb registers");

		apb_access(arcade_cfg_pkg::ADDR_RESET, 1'b1, $urandom);
		wait_reset_done();
		apb_access(arcade_cfg_pkg::ADDR_RESET, 1'b1, '0);
		repeat (6) next_cycle();
		apb_access(arcade_cfg_pkg::ADDR_RESET, 1'b1, '0); // restart mid pulse
		wait_reset_done();
		u_chk.end_test("core reset pulse");

		for (int lvl = 0; lvl < 4; lvl++) begin
			apb_access(arcade_cfg_pkg::ADDR_CFG, 1'b1, 32'(lvl << 1));
			for (int i = 0; i < 200; i++) begin
				next_cycle();
				video_in.r = 6'($urandom);
				video_in.g = 6'($urandom);
				video_in.b = 6'($urandom);
				video_in.hs = (i % 25) < 3;
				video_in.vs = i < 10;
			end
		end
		video_in = '0;
		u_chk.end_test("scanline dimming");

		repeat (6) begin
			next_cycle();
			sample = 8'($urandom);
			repeat (260) next_cycle(); // one full window plus pipeline
		end
		u_chk.end_test("sigma-delta audio");

		next_cycle();
		u_chk.print_counts();
		if (u_chk.tests_bad == 0 && !timed_out)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- all.f
arcade_cfg_pkg.sv
arcade_io_pkg.sv
key_decoder.sv
control_mapper.sv
io_ctrl.sv
audio_dac.sv
scanline_dimmer.sv
arcade_io_top.sv
arcade_io_checker.sv
tb_arcade_io.sv
